//--- sources.f
+incdir+verilog
verilog/pyramid_pkg.sv
verilog/frame_ram_if.sv
verilog/frame_ram.sv
verilog/pixel_loader.sv
verilog/octave_downsampler.sv
verilog/octave_sender.sv
verilog/pyramid_top.sv
dv/pyramid_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pyramid testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module pyramid_tb \
    -f sources.f \
    -o pyramid_sim

out=$(./obj_dir/pyramid_sim)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

//--- dv/pyramid_tb.sv
`timescale 1ns/1ps
`include "pyramid_config.svh"

module pyramid_tb import pyramid_pkg::*; ();

    localparam int HALF_W     = `IMG_WIDTH / 2;
    localparam int NUM_CASES  = 5;
    localparam int DONE_BOUND = 5 * HALF_PIXELS + 4;          // worst downsample latency
    localparam int SEND_LEN   = HALF_PIXELS * `TX_SPACING;  // one full stream

    typedef enum int {FILL_CONST, FILL_RAMP, FILL_RANDOM} fill_t;

    // one table row
    typedef struct {
        fill_t  kind;
        pixel_t value;      // constant level or ramp start
        int     gap;        // idle cycles between input bytes
        int     extra;      // bytes sent after the frame
        pixel_t exp_const;  // expected octave byte, constant rows
    } case_t;

    logic   clk_100mhz;
    logic   sys_rst;
    pixel_t rx_data;
    logic   rx_valid;
    logic   send;
    pixel_t tx_data;
    logic   tx_valid;
    logic   tx_busy;
    logic   image_received;
    logic   pyramid_done;

    case_t  cases [NUM_CASES];
    pixel_t frame [FULL_PIXELS];      // frame as driven
    pixel_t expected [HALF_PIXELS];   // reference octave
    pixel_t got_q [$];                // captured output bytes
    int     got_cyc_q [$];            // cycle of each strobe
    int     cycle;
    int     limit_cycles;
    integer seed;
    int     pixel_errors;
    int     flag_errors;
    int     stream_errors;

    pyramid_top dut_i (
        .clk_100mhz       (clk_100mhz),
        .sys_rst          (sys_rst),
        .rx_data_i        (rx_data),
        .rx_valid_i       (rx_valid),
        .send_i           (send),
        .tx_data_o        (tx_data),
        .tx_valid_o       (tx_valid),
        .tx_busy_o        (tx_busy),
        .image_received_o (image_received),
        .pyramid_done_o   (pyramid_done)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;  // 100 MHz
    end

    always @(posedge clk_100mhz) cycle <= cycle + 1;

    // output monitor, sampled mid-cycle
    always @(negedge clk_100mhz) begin
        if (!sys_rst && tx_valid) begin
            got_q.push_back(tx_data);
            got_cyc_q.push_back(cycle);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_100mhz);
        $display("watchdog expired after %0d cycles, run did not complete", limit_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            $display("Fail %0t: %s expected %02h got %02h", $time, name, exp, act);
            pixel_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %0t: %s expected %b got %b", $time, name, exp, act);
            flag_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %0t: %s expected %0d got %0d", $time, name, exp, act);
            stream_errors++;
        end
    endtask

    task automatic fill_table();
        cases[0] = '{FILL_CONST,  8'h5a, 0, 3, 8'h5a};
        cases[1] = '{FILL_RAMP,   8'h10, 1, 0, 8'h00};  // odd step, truncation shows
        cases[2] = '{FILL_RANDOM, 8'h00, 2, 4, 8'h00};
        cases[3] = '{FILL_CONST,  8'hff, 0, 1, 8'hff};  // sum needs the spare bits
        cases[4] = '{FILL_RANDOM, 8'h00, 0, 2, 8'h00};
    endtask

    // frame for row k and its truncated 2x2 averages
    task automatic build_frame(input int k);
        int x;
        int base;
        int sum;
        for (int a = 0; a < FULL_PIXELS; a++) begin
            x = a % `IMG_WIDTH;
            case (cases[k].kind)
                FILL_CONST: frame[a] = cases[k].value;
                FILL_RAMP:  frame[a] = pixel_t'(int'(cases[k].value) + 17 * x);
                default:    frame[a] = pixel_t'($random(seed));
            endcase
        end
        for (int r = 0; r < `IMG_HEIGHT / 2; r++) begin
            for (int c = 0; c < HALF_W; c++) begin
                base = 2 * r * `IMG_WIDTH + 2 * c;  // top left of the block
                sum  = int'(frame[base]) + int'(frame[base + 1])
                     + int'(frame[base + `IMG_WIDTH]) + int'(frame[base + `IMG_WIDTH + 1]);
                if (cases[k].kind == FILL_CONST)
                    expected[r * HALF_W + c] = cases[k].exp_const;  // from the table
                else
                    expected[r * HALF_W + c] = pixel_t'(sum / 4);
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_100mhz);
        sys_rst  <= 1'b1;
        rx_valid <= 1'b0;
        send     <= 1'b0;
        repeat (8) @(posedge clk_100mhz);
        sys_rst <= 1'b0;
        @(negedge clk_100mhz);
        got_q.delete();
        got_cyc_q.delete();
        check_flag("image_received_o", 1'b0, image_received);
        check_flag("pyramid_done_o", 1'b0, pyramid_done);
        check_flag("tx_valid_o", 1'b0, tx_valid);
        check_flag("tx_busy_o", 1'b0, tx_busy);
    endtask

    task automatic pulse_send();
        @(posedge clk_100mhz);
        send <= 1'b1;
        @(posedge clk_100mhz);
        send <= 1'b0;
    endtask

    task automatic load_frame(input int gap);
        for (int i = 0; i < FULL_PIXELS; i++) begin
            @(posedge clk_100mhz);
            rx_valid <= 1'b1;
            rx_data  <= frame[i];
            @(negedge clk_100mhz);
            check_flag("image_received_o", 1'b0, image_received);  // i bytes taken so far
            repeat (gap) begin
                @(posedge clk_100mhz);
                rx_valid <= 1'b0;
            end
        end
        @(posedge clk_100mhz);
        rx_valid <= 1'b0;
        @(negedge clk_100mhz);
        check_flag("image_received_o", 1'b1, image_received);
    endtask

    // bytes past the frame, inverted so a leak would show
    task automatic send_extra(input int count, input int gap);
        for (int e = 0; e < count; e++) begin
            @(posedge clk_100mhz);
            rx_valid <= 1'b1;
            rx_data  <= ~frame[e];
            repeat (gap) begin
                @(posedge clk_100mhz);
                rx_valid <= 1'b0;
            end
        end
        @(posedge clk_100mhz);
        rx_valid <= 1'b0;
        @(negedge clk_100mhz);
        check_flag("image_received_o", 1'b1, image_received);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!pyramid_done && n < DONE_BOUND) begin
            @(negedge clk_100mhz);
            n++;
        end
        if (!pyramid_done) begin
            $display("timeout, pyramid_done_o still low after %0d cycles", DONE_BOUND);
            stream_errors++;
        end
        if (got_q.size() != 0) begin
            $display("%0d bytes came out before pyramid_done_o rose", got_q.size());
            stream_errors++;
        end
    endtask

    task automatic run_stream(input int pass);
        int n;
        got_q.delete();
        got_cyc_q.delete();
        pulse_send();
        n = 0;
        while (got_q.size() < 2 && n < SEND_LEN) begin
            @(negedge clk_100mhz);
            n++;
        end
        pulse_send();  // mid-stream, sender is busy
        n = 0;
        while (tx_busy && n < SEND_LEN + 8) begin
            @(negedge clk_100mhz);
            n++;
        end
        if (tx_busy) begin
            $display("timeout, tx_busy_o stuck high in send %0d", pass);
            stream_errors++;
        end
        repeat (2 * `TX_SPACING) @(negedge clk_100mhz);  // a restarted stream shows here
        check_flag("tx_busy_o", 1'b0, tx_busy);
        if (got_q.size() != HALF_PIXELS) begin
            $display("send %0d gave %0d bytes, expected %0d", pass, got_q.size(), HALF_PIXELS);
            stream_errors++;
        end
        for (int i = 0; i < got_q.size() && i < HALF_PIXELS; i++) begin
            check_pixel($sformatf("tx_data_o[%0d]", i), expected[i], got_q[i]);
            if (i > 0)
                check_count("tx_valid_o spacing", `TX_SPACING, got_cyc_q[i] - got_cyc_q[i-1]);
        end
    endtask

    initial begin
        sys_rst       = 1'b1;
        rx_data       = '0;
        rx_valid      = 1'b0;
        send          = 1'b0;
        seed          = 32'h75db_d9e6;
        pixel_errors  = 0;
        flag_errors   = 0;
        stream_errors = 0;
        fill_table();
        // reset, load, downsample and two streams per row, plus slack
        limit_cycles = 200;
        for (int k = 0; k < NUM_CASES; k++)
            limit_cycles += 10 + (FULL_PIXELS + cases[k].extra) * (cases[k].gap + 1)
                          + DONE_BOUND + 2 * (SEND_LEN + 30);
        for (int k = 0; k < NUM_CASES; k++) begin
            build_frame(k);
            apply_reset();
            load_frame(cases[k].gap);
            check_flag("pyramid_done_o", 1'b0, pyramid_done);
            send_extra(cases[k].extra, cases[k].gap);  // first blocks still being read
            pulse_send();  // octave not ready yet
            wait_done();
            run_stream(1);
            run_stream(2);  // replay
        end
        $display("errors: pixel %0d, flag %0d, stream %0d",
                 pixel_errors, flag_errors, stream_errors);
        if (pixel_errors + flag_errors + stream_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verilog/pyramid_top.sv
`timescale 1ns/1ps
`default_nettype none

// one-octave pyramid, byte in and byte out
module pyramid_top import pyramid_pkg::*; (
    input  logic   clk_100mhz,
    input  logic   sys_rst,
    input  pixel_t rx_data_i,
    input  logic   rx_valid_i,
    input  logic   send_i,
    output pixel_t tx_data_o,
    output logic   tx_valid_o,
    output logic   tx_busy_o,
    output logic   image_received_o,
    output logic   pyramid_done_o
);

    logic frame_start;   // loader to downsampler
    logic octave_ready;  // downsampler to sender

    // memory buses
    frame_ram_if #(.ADDR_BITS($bits(full_addr_t))) full_if ();
    frame_ram_if #(.ADDR_BITS($bits(half_addr_t))) half_if ();

    frame_ram #(.ADDR_BITS($bits(full_addr_t))) full_ram_i (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .mem_if     (full_if.mem)
    );

    frame_ram #(.ADDR_BITS($bits(half_addr_t))) half_ram_i (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .mem_if     (half_if.mem)
    );

    pixel_loader loader_i (
        .clk_100mhz       (clk_100mhz),
        .sys_rst          (sys_rst),
        .rx_data_i        (rx_data_i),
        .rx_valid_i       (rx_valid_i),
        .wr_if            (full_if.writer),
        .frame_start_o    (frame_start),
        .image_received_o (image_received_o)
    );

    octave_downsampler down_i (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .frame_start_i  (frame_start),
        .rd_if          (full_if.reader),
        .wr_if          (half_if.writer),
        .octave_ready_o (octave_ready)
    );

    octave_sender sender_i (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .octave_ready_i (octave_ready),
        .send_i         (send_i),
        .rd_if          (half_if.reader),
        .tx_data_o      (tx_data_o),
        .tx_valid_o     (tx_valid_o),
        .tx_busy_o      (tx_busy_o)
    );

    assign pyramid_done_o = octave_ready;  // status level

endmodule

`default_nettype wire

//--- verilog/octave_sender.sv
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_config.svh"

// paced byte stream of the half-size octave
module octave_sender import pyramid_pkg::*; (
    input  logic          clk_100mhz,
    input  logic          sys_rst,
    input  logic          octave_ready_i,  // octave fully written
    input  logic          send_i,          // request pulse
    frame_ram_if.reader   rd_if,           // half-size octave
    output pixel_t        tx_data_o,
    output logic          tx_valid_o,      // one-cycle byte strobe
    output logic          tx_busy_o
);

    localparam int TICK_BITS = (`TX_SPACING > 1) ? $clog2(`TX_SPACING) : 1;

    logic                 send_ok;    // accepted request
    logic                 busy_q;
    logic [TICK_BITS-1:0] tick_q;     // spacing counter
    half_addr_t           rd_ptr_q;   // next byte to fetch
    logic                 last_q;     // final byte already taken
    logic                 take_byte;
    logic                 tx_valid_q;
    pixel_t               tx_data_q;

    assign send_ok = send_i && octave_ready_i && !busy_q;  // ignored otherwise

    // tick 0 presents the address, tick 1 sees the word
    assign take_byte = busy_q && !last_q && (tick_q == TICK_BITS'(1));

    assign rd_if.rd_addr = rd_ptr_q;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            busy_q     <= 1'b0;
            tick_q     <= '0;
            rd_ptr_q   <= '0;
            last_q     <= 1'b0;
            tx_valid_q <= 1'b0;
        end else begin
            tx_valid_q <= take_byte;
            if (send_ok) begin  // replay starts from address zero
                busy_q   <= 1'b1;
                tick_q   <= '0;
                rd_ptr_q <= '0;
                last_q   <= 1'b0;
            end else if (busy_q) begin
                tick_q <= (tick_q == TICK_BITS'(`TX_SPACING - 1)) ? '0 : tick_q + 1'b1;
                if (take_byte) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                    if (rd_ptr_q == half_addr_t'(HALF_PIXELS - 1)) begin
                        last_q <= 1'b1;
                    end
                end
                if (tx_valid_q && last_q) begin  // drop after final strobe
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (take_byte) begin
            tx_data_q <= rd_if.rd_data;
        end
    end

    assign tx_data_o  = tx_data_q;
    assign tx_valid_o = tx_valid_q;
    assign tx_busy_o  = busy_q;

    // no stray strobe outside a transfer
    a_valid_in_busy: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        tx_valid_o |-> tx_busy_o)
        else $error("tx_valid_o outside tx_busy_o");

endmodule

`default_nettype wire

//--- verilog/octave_downsampler.sv
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_config.svh"

// 2x2 box average of the full frame into the half-size octave
module octave_downsampler import pyramid_pkg::*; (
    input  logic          clk_100mhz,
    input  logic          sys_rst,
    input  logic          frame_start_i,   // frame stored, go
    frame_ram_if.reader   rd_if,           // full frame
    frame_ram_if.writer   wr_if,           // half-size octave
    output logic          octave_ready_o   // held until reset
);

    localparam int HALF_W   = `IMG_WIDTH / 2;
    localparam int HALF_H   = `IMG_HEIGHT / 2;
    localparam int COL_BITS = (HALF_W > 1) ? $clog2(HALF_W) : 1;
    localparam int ROW_BITS = (HALF_H > 1) ? $clog2(HALF_H) : 1;

    // read issue stage
    logic                   running_q;
    logic [ROW_BITS-1:0]    row_q;      // output row r
    logic [COL_BITS-1:0]    col_q;      // output column c
    logic [1:0]             phase_q;    // tap, bit1 picks row, bit0 picks column
    logic                   last_tap;
    full_addr_t             src_addr;
    half_addr_t             dst_addr;

    // data return stage
    logic                   s1_valid_q;
    logic [1:0]             s1_phase_q;
    logic                   s1_last_q;
    half_addr_t             s1_addr_q;
    logic [`PIXEL_BITS+1:0] acc_q;      // four-tap sum, two spare bits

    // write stage
    logic                   wr_pend_q;
    logic                   wr_last_q;
    half_addr_t             wr_addr_q;

    logic                   pass_busy;

    assign last_tap = (phase_q == 2'd3) &&
                      (col_q == COL_BITS'(HALF_W - 1)) &&
                      (row_q == ROW_BITS'(HALF_H - 1));

    // rows 2r and 2r+1, columns 2c and 2c+1
    assign src_addr = full_addr_t'((2 * row_q + phase_q[1]) * `IMG_WIDTH
                                   + 2 * col_q + phase_q[0]);
    assign dst_addr = half_addr_t'(row_q * HALF_W + col_q);  // r*half width + c

    assign rd_if.rd_addr = src_addr;

    // one tap per cycle, no gaps between output pixels
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            running_q <= 1'b0;
            row_q     <= '0;
            col_q     <= '0;
            phase_q   <= '0;
        end else if (!running_q) begin
            if (frame_start_i) begin
                running_q <= 1'b1;
                row_q     <= '0;
                col_q     <= '0;
                phase_q   <= '0;
            end
        end else begin
            phase_q <= phase_q + 2'd1;
            if (phase_q == 2'd3) begin  // pixel done, step the walk
                if (col_q == COL_BITS'(HALF_W - 1)) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            if (last_tap) begin
                running_q <= 1'b0;
            end
        end
    end

    // control through the pipe
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            s1_valid_q     <= 1'b0;
            wr_pend_q      <= 1'b0;
            octave_ready_o <= 1'b0;
        end else begin
            s1_valid_q <= running_q;                         // datum arrives next cycle
            wr_pend_q  <= s1_valid_q && (s1_phase_q == 2'd3);  // sum complete
            if (wr_pend_q && wr_last_q) begin
                octave_ready_o <= 1'b1;
            end
        end
    end

    // payload follows the taps
    always_ff @(posedge clk_100mhz) begin
        s1_phase_q <= phase_q;
        s1_last_q  <= last_tap;
        s1_addr_q  <= dst_addr;
        wr_addr_q  <= s1_addr_q;
        wr_last_q  <= s1_last_q;
        if (s1_valid_q) begin
            if (s1_phase_q == 2'd0) begin  // first tap restarts the sum
                acc_q <= {2'b00, rd_if.rd_data};
            end else begin
                acc_q <= acc_q + {2'b00, rd_if.rd_data};
            end
        end
    end

    // divide by four, truncating
    assign wr_if.wr_en   = wr_pend_q;
    assign wr_if.wr_addr = wr_addr_q;
    assign wr_if.wr_data = acc_q[`PIXEL_BITS+1:2];

    assign pass_busy = running_q || s1_valid_q || wr_pend_q;

    // loader must not restart a pass still in flight
    a_no_restart: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        frame_start_i |-> !pass_busy)
        else $error("frame_start during downsample pass");

endmodule

`default_nettype wire

//--- verilog/pixel_loader.sv
`timescale 1ns/1ps
`default_nettype none

// raster-order writer of the incoming frame
module pixel_loader import pyramid_pkg::*; (
    input  logic          clk_100mhz,
    input  logic          sys_rst,
    input  pixel_t        rx_data_i,         // byte from the receiver
    input  logic          rx_valid_i,        // one-cycle strobe
    frame_ram_if.writer   wr_if,             // full frame memory
    output logic          frame_start_o,     // kicks the downsampler
    output logic          image_received_o   // frame complete, held
);

    full_addr_t addr_q;  // next raster position
    logic       take;    // byte accepted this cycle

    // once the frame is full everything else is dropped
    assign take = rx_valid_i && !image_received_o;

    // write lands in the same cycle as the strobe
    assign wr_if.wr_en   = take;
    assign wr_if.wr_addr = addr_q;
    assign wr_if.wr_data = rx_data_i;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            addr_q           <= '0;
            image_received_o <= 1'b0;
            frame_start_o    <= 1'b0;
        end else begin
            frame_start_o <= 1'b0;  // single pulse
            if (take) begin
                addr_q <= addr_q + 1'b1;
                if (addr_q == full_addr_t'(FULL_PIXELS - 1)) begin  // last pixel
                    image_received_o <= 1'b1;
                    frame_start_o    <= 1'b1;
                end
            end
        end
    end

    // bytes after the full frame must not move the write pointer
    a_ignore_after_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        (rx_valid_i && image_received_o) |=> $stable(addr_q))
        else $error("pixel_loader took a byte after frame complete");

endmodule

`default_nettype wire

//--- verilog/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

// simple dual-port ram, read-first, one cycle read latency
module frame_ram import pyramid_pkg::*; #(
    parameter int ADDR_BITS = 6
) (
    input  logic      clk_100mhz,
    input  logic      sys_rst,
    frame_ram_if.mem  mem_if
);

    localparam int DEPTH = 1 << ADDR_BITS;

    pixel_t mem [DEPTH];  // maps to block ram
    pixel_t rd_q;         // registered read word

    always_ff @(posedge clk_100mhz) begin
        if (mem_if.wr_en) begin
            mem[mem_if.wr_addr] <= mem_if.wr_data;
        end
        rd_q <= mem[mem_if.rd_addr];  // old word on same-address collision
    end

    assign mem_if.rd_data = rd_q;

    // interface width has to agree with this instance's depth
    a_wr_in_range: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        mem_if.wr_en |-> (mem_if.wr_addr < DEPTH))
        else $error("frame_ram write past depth %0d", DEPTH);

endmodule

`default_nettype wire

//--- verilog/frame_ram_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_config.svh"

// one write port and one read port of a frame memory
interface frame_ram_if #(
    parameter int ADDR_BITS = 6  // full or half frame depth
);

    logic                   wr_en;    // write strobe
    logic [ADDR_BITS-1:0]   wr_addr;
    logic [`PIXEL_BITS-1:0] wr_data;
    logic [ADDR_BITS-1:0]   rd_addr;  // sampled every edge
    logic [`PIXEL_BITS-1:0] rd_data;  // word at last sampled rd_addr

    // producer stage
    modport writer (output wr_en, wr_addr, wr_data);

    // consumer stage, reads always on
    modport reader (output rd_addr, input rd_data);

    // the memory itself
    modport mem (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);

endinterface

`default_nettype wire

//--- verilog/pyramid_pkg.sv
`include "pyramid_config.svh"

package pyramid_pkg;

    // pixel counts of the two image levels
    localparam int FULL_PIXELS = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int HALF_PIXELS = FULL_PIXELS / 4;  // one octave down

    // one greyscale sample
    typedef logic [`PIXEL_BITS-1:0] pixel_t;

    // raster addresses into each memory
    typedef logic [$clog2(FULL_PIXELS)-1:0] full_addr_t;
    typedef logic [$clog2(HALF_PIXELS)-1:0] half_addr_t;

endpackage

//--- verilog/pyramid_config.svh
`ifndef PYRAMID_CONFIG_SVH
`define PYRAMID_CONFIG_SVH

// frame geometry, full size
`define IMG_WIDTH 8   // pixels per row
`define IMG_HEIGHT 8  // rows per frame

// greyscale depth of one sample
`define PIXEL_BITS 8

// clocks between output byte strobes
// sender needs at least two
`define TX_SPACING 4

`endif
